//--- src.f
+incdir+hdl
hdl/xbar_pkg.sv
hdl/axi_read_ifs.sv
hdl/ar_master_select.sv
hdl/ar_slave_steer.sv
hdl/r_slave_select.sv
hdl/r_master_steer.sv
hdl/axi_read_xbar.sv
verification/tb_axi_read_xbar.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_axi_read_xbar
FILELIST  = src.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_axi_read_xbar.sv
`timescale 1ns/1ps
`include "xbar_settings.svh"

module tb_axi_read_xbar import xbar_pkg::*; ();

    // six tests of at most this many cycles each
    localparam int NUM_TESTS       = 6;
    localparam int TEST_CYCLES     = 40;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + 60;

    logic aclk = 1'b0;
    logic reset;
    int   seed;

    // master side
    logic [`XBAR_ADDR_W-1:0]  m_araddr  [`XBAR_NUM_PORTS];
    logic [`XBAR_LEN_W-1:0]   m_arlen   [`XBAR_NUM_PORTS];
    logic [`XBAR_SIZE_W-1:0]  m_arsize  [`XBAR_NUM_PORTS];
    logic [`XBAR_BURST_W-1:0] m_arburst [`XBAR_NUM_PORTS];
    axi_id_u                  m_arid    [`XBAR_NUM_PORTS];
    logic                     m_arvalid [`XBAR_NUM_PORTS];
    logic                     m_arready [`XBAR_NUM_PORTS];
    logic [`XBAR_DATA_W-1:0]  m_rdata   [`XBAR_NUM_PORTS];
    logic [`XBAR_RESP_W-1:0]  m_rresp   [`XBAR_NUM_PORTS];
    logic                     m_rlast   [`XBAR_NUM_PORTS];
    axi_id_u                  m_rid     [`XBAR_NUM_PORTS];
    logic                     m_rvalid  [`XBAR_NUM_PORTS];
    logic                     m_rready  [`XBAR_NUM_PORTS];
    // slave side
    logic [`XBAR_ADDR_W-1:0]  s_araddr  [`XBAR_NUM_PORTS];
    logic [`XBAR_LEN_W-1:0]   s_arlen   [`XBAR_NUM_PORTS];
    logic [`XBAR_SIZE_W-1:0]  s_arsize  [`XBAR_NUM_PORTS];
    logic [`XBAR_BURST_W-1:0] s_arburst [`XBAR_NUM_PORTS];
    axi_id_u                  s_arid    [`XBAR_NUM_PORTS];
    logic                     s_arvalid [`XBAR_NUM_PORTS];
    logic                     s_arready [`XBAR_NUM_PORTS];
    logic [`XBAR_DATA_W-1:0]  s_rdata   [`XBAR_NUM_PORTS];
    logic [`XBAR_RESP_W-1:0]  s_rresp   [`XBAR_NUM_PORTS];
    logic                     s_rlast   [`XBAR_NUM_PORTS];
    axi_id_u                  s_rid     [`XBAR_NUM_PORTS];
    logic                     s_rvalid  [`XBAR_NUM_PORTS];
    logic                     s_rready  [`XBAR_NUM_PORTS];

    axi_read_xbar u_axi_read_xbar (.*);

    // 40 ns period
    always #20 aclk = ~aclk;

    // **************************************************
    // helpers
    // **************************************************
    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    // port number to thermometer code
    function automatic logic [`XBAR_CODE_W-1:0] port_code(input int p);
        case (p)
            0:       return 3'b001;
            1:       return 3'b011;
            default: return 3'b111;
        endcase
    endfunction

    function automatic axi_id_u make_id(input int m, input int s);
        axi_id_u id;
        id.fields.master_code = port_code(m);
        id.fields.slave_code  = port_code(s);
        return id;
    endfunction

    // highest numbered requester wins
    // -1 when nobody asks
    function automatic int highest_port(input logic [`XBAR_NUM_PORTS-1:0] mask);
        int win;
        win = -1;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            if (mask[i]) begin
                win = i;
            end
        end
        return win;
    endfunction

    // drive just after the rising edge
    task automatic drive_edge();
        @(posedge aclk);
        #2;
    endtask

    // sample half a period later
    task automatic sample_mid();
        @(negedge aclk);
    endtask

    // drop all valids and raise all readies
    // old payload stays on the idle ports
    task automatic drop_valids();
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            m_arvalid[i] = 1'b0;
            s_rvalid[i]  = 1'b0;
            s_arready[i] = 1'b1;
            m_rready[i]  = 1'b1;
        end
    endtask

    task automatic init_inputs();
        reset = 1'b1;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            m_araddr[i]   = '0;
            m_arlen[i]    = '0;
            m_arsize[i]   = '0;
            m_arburst[i]  = '0;
            m_arid[i].raw = '0;
            m_arvalid[i]  = 1'b0;
            m_rready[i]   = 1'b0;
            s_arready[i]  = 1'b0;
            s_rdata[i]    = '0;
            s_rresp[i]    = '0;
            s_rlast[i]    = 1'b0;
            s_rid[i].raw  = '0;
            s_rvalid[i]   = 1'b0;
        end
    endtask

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic check_id(input string test, input string what, input axi_id_u exp,
                            input axi_id_u act);
        if (exp.raw !== act.raw) begin
            $display("Error: %s %s expected %h actual %h", test, what, exp.raw, act.raw);
            abort_run();
        end
    endtask

    task automatic check_word(input string test, input string what,
                              input logic [`XBAR_DATA_W-1:0] exp,
                              input logic [`XBAR_DATA_W-1:0] act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test, what, exp, act);
            abort_run();
        end
    endtask

    // narrow fields widened to the len width
    task automatic check_field(input string test, input string what,
                               input logic [`XBAR_LEN_W-1:0] exp,
                               input logic [`XBAR_LEN_W-1:0] act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string test, input string what, input logic exp,
                             input logic act);
        if (exp !== act) begin
            $display("Error: %s %s expected %b actual %b", test, what, exp, act);
            abort_run();
        end
    endtask

    // slave s gets the request and master m gets ready
    // no slave at all when s is negative
    task automatic compare_ar_side(input string test, input int m, input int s,
                                   input logic [`XBAR_ADDR_W-1:0] addr,
                                   input logic [`XBAR_LEN_W-1:0] len,
                                   input logic [`XBAR_SIZE_W-1:0] size,
                                   input logic [`XBAR_BURST_W-1:0] burst,
                                   input axi_id_u id, input logic rdy);
        logic    sel;
        axi_id_u exp_id;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            sel        = (i == s);
            exp_id.raw = sel ? id.raw : '0;
            check_bit(test, "s_arvalid", sel, s_arvalid[i]);
            check_word(test, "s_araddr", sel ? addr : '0, s_araddr[i]);
            check_field(test, "s_arlen", sel ? len : '0, s_arlen[i]);
            check_field(test, "s_arsize", 4'(sel ? size : 3'd0), 4'(s_arsize[i]));
            check_field(test, "s_arburst", 4'(sel ? burst : 2'd0), 4'(s_arburst[i]));
            check_id(test, "s_arid", exp_id, s_arid[i]);
            check_bit(test, "m_arready", (i == m) && (s >= 0) && rdy, m_arready[i]);
        end
    endtask

    // master m gets the beat and slave s gets ready
    task automatic compare_r_side(input string test, input int s, input int m,
                                  input logic [`XBAR_DATA_W-1:0] data,
                                  input logic [`XBAR_RESP_W-1:0] resp,
                                  input logic last, input axi_id_u id, input logic rdy);
        logic    sel;
        axi_id_u exp_id;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            sel        = (i == m);
            exp_id.raw = sel ? id.raw : '0;
            check_bit(test, "m_rvalid", sel, m_rvalid[i]);
            check_word(test, "m_rdata", sel ? data : '0, m_rdata[i]);
            check_field(test, "m_rresp", 4'(sel ? resp : 2'd0), 4'(m_rresp[i]));
            check_bit(test, "m_rlast", sel & last, m_rlast[i]);
            check_id(test, "m_rid", exp_id, m_rid[i]);
            check_bit(test, "s_rready", (i == s) && (m >= 0) && rdy, s_rready[i]);
        end
    endtask

    // drive one master request and one slave beat onto the inputs
    task automatic put_request(input int m, input int s);
        m_araddr[m]  = $random(seed);
        m_arlen[m]   = 4'(m * 3 + s);
        m_arsize[m]  = 3'(s + 1);
        m_arburst[m] = 2'(m);
        m_arid[m]    = make_id(m, s);
        m_arvalid[m] = 1'b1;
    endtask

    task automatic put_beat(input int s, input int m);
        s_rdata[s]  = $random(seed);
        s_rresp[s]  = 2'(s + m);
        s_rlast[s]  = (s != m);
        s_rid[s]    = make_id(m, s);
        s_rvalid[s] = 1'b1;
    endtask

    // **************************************************
    // directed tests
    // **************************************************
    task automatic idle_outputs(input string test);
        axi_id_u zero_id;
        zero_id.raw = '0;
        sample_mid();
        compare_ar_side(test, -1, -1, '0, '0, '0, '0, zero_id, 1'b0);
        compare_r_side(test, -1, -1, '0, '0, 1'b0, zero_id, 1'b0);
    endtask

    task automatic route_requests();
        for (int m = 0; m < `XBAR_NUM_PORTS; m++) begin
            for (int s = 0; s < `XBAR_NUM_PORTS; s++) begin
                drive_edge();
                drop_valids();
                put_request(m, s);
                sample_mid();
                compare_ar_side("route_requests", m, s, m_araddr[m], m_arlen[m],
                                m_arsize[m], m_arburst[m], m_arid[m], 1'b1);
            end
        end
    endtask

    // master 1 only wins once master 2 lets go
    task automatic arbitrate_requests();
        logic [`XBAR_NUM_PORTS-1:0] masks [4] = '{3'b111, 3'b011, 3'b001, 3'b101};
        int win;
        for (int k = 0; k < 4; k++) begin
            drive_edge();
            drop_valids();
            for (int m = 0; m < `XBAR_NUM_PORTS; m++) begin
                if (masks[k][m]) begin
                    put_request(m, 2 - m);
                end
            end
            sample_mid();
            win = highest_port(masks[k]);
            compare_ar_side("arbitrate_requests", win, 2 - win, m_araddr[win], m_arlen[win],
                            m_arsize[win], m_arburst[win], m_arid[win], 1'b1);
        end
    endtask

    task automatic reject_bad_slave_code();
        logic [`XBAR_CODE_W-1:0] bad [5] = '{3'b000, 3'b010, 3'b100, 3'b101, 3'b110};
        for (int k = 0; k < 5; k++) begin
            drive_edge();
            drop_valids();
            put_request(1, 0);
            m_arid[1].fields.slave_code = bad[k];
            sample_mid();
            // no slave and no ready anywhere
            compare_ar_side("reject_bad_slave_code", 1, -1, '0, '0, '0, '0, m_arid[1], 1'b0);
        end
    endtask

    task automatic route_responses();
        logic [`XBAR_NUM_PORTS-1:0] masks [4] = '{3'b101, 3'b011, 3'b111, 3'b110};
        int win;
        for (int s = 0; s < `XBAR_NUM_PORTS; s++) begin
            for (int m = 0; m < `XBAR_NUM_PORTS; m++) begin
                drive_edge();
                drop_valids();
                put_beat(s, m);
                sample_mid();
                compare_r_side("route_responses", s, m, s_rdata[s], s_rresp[s], s_rlast[s],
                               s_rid[s], 1'b1);
            end
        end
        // higher slave code takes the channel
        for (int k = 0; k < 4; k++) begin
            drive_edge();
            drop_valids();
            for (int s = 0; s < `XBAR_NUM_PORTS; s++) begin
                if (masks[k][s]) begin
                    put_beat(s, (s + 1) % `XBAR_NUM_PORTS);
                end
            end
            sample_mid();
            win = highest_port(masks[k]);
            compare_r_side("response_priority", win, (win + 1) % `XBAR_NUM_PORTS, s_rdata[win],
                           s_rresp[win], s_rlast[win], s_rid[win], 1'b1);
        end
    endtask

    task automatic hold_back_pressure();
        // slave 1 stalls master 0's request
        drive_edge();
        drop_valids();
        put_request(0, 1);
        s_arready[1] = 1'b0;
        sample_mid();
        compare_ar_side("back_pressure_ar", 0, 1, m_araddr[0], m_arlen[0], m_arsize[0],
                        m_arburst[0], m_arid[0], 1'b0);
        drive_edge();
        s_arready[1] = 1'b1;
        sample_mid();
        compare_ar_side("back_pressure_ar", 0, 1, m_araddr[0], m_arlen[0], m_arsize[0],
                        m_arburst[0], m_arid[0], 1'b1);
        // master 1 stalls slave 2's beat
        drive_edge();
        drop_valids();
        put_beat(2, 1);
        m_rready[1] = 1'b0;
        sample_mid();
        compare_r_side("back_pressure_r", 2, 1, s_rdata[2], s_rresp[2], s_rlast[2],
                       s_rid[2], 1'b0);
        drive_edge();
        m_rready[1] = 1'b1;
        sample_mid();
        compare_r_side("back_pressure_r", 2, 1, s_rdata[2], s_rresp[2], s_rlast[2],
                       s_rid[2], 1'b1);
    endtask

    // **************************************************
    // main sequence and watchdog
    // **************************************************
    initial begin
        seed = 32'h1caddb99;
        init_inputs();
        // five cycles of reset with an idle check inside
        repeat (2) @(posedge aclk);
        idle_outputs("idle_in_reset");
        repeat (3) @(posedge aclk);
        #2;
        reset = 1'b0;
        // junk ids on idle ports must not matter
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            m_arid[i].raw = 6'(7 * i + 5);
            s_rid[i].raw  = 6'(9 * i + 3);
        end
        idle_outputs("idle_after_reset");
        route_requests();
        arbitrate_requests();
        reject_bad_slave_code();
        route_responses();
        hold_back_pressure();
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

//--- hdl/axi_read_xbar.sv
`timescale 1ns/1ps
`include "xbar_settings.svh"

module axi_read_xbar import xbar_pkg::*; (
    input  logic                     aclk,
    input  logic                     reset,
    // master side, read address
    input  logic [`XBAR_ADDR_W-1:0]  m_araddr  [`XBAR_NUM_PORTS],
    input  logic [`XBAR_LEN_W-1:0]   m_arlen   [`XBAR_NUM_PORTS],
    input  logic [`XBAR_SIZE_W-1:0]  m_arsize  [`XBAR_NUM_PORTS],
    input  logic [`XBAR_BURST_W-1:0] m_arburst [`XBAR_NUM_PORTS],
    input  axi_id_u                  m_arid    [`XBAR_NUM_PORTS],
    input  logic                     m_arvalid [`XBAR_NUM_PORTS],
    output logic                     m_arready [`XBAR_NUM_PORTS],
    // master side, read data
    output logic [`XBAR_DATA_W-1:0]  m_rdata   [`XBAR_NUM_PORTS],
    output logic [`XBAR_RESP_W-1:0]  m_rresp   [`XBAR_NUM_PORTS],
    output logic                     m_rlast   [`XBAR_NUM_PORTS],
    output axi_id_u                  m_rid     [`XBAR_NUM_PORTS],
    output logic                     m_rvalid  [`XBAR_NUM_PORTS],
    input  logic                     m_rready  [`XBAR_NUM_PORTS],
    // slave side, read address
    output logic [`XBAR_ADDR_W-1:0]  s_araddr  [`XBAR_NUM_PORTS],
    output logic [`XBAR_LEN_W-1:0]   s_arlen   [`XBAR_NUM_PORTS],
    output logic [`XBAR_SIZE_W-1:0]  s_arsize  [`XBAR_NUM_PORTS],
    output logic [`XBAR_BURST_W-1:0] s_arburst [`XBAR_NUM_PORTS],
    output axi_id_u                  s_arid    [`XBAR_NUM_PORTS],
    output logic                     s_arvalid [`XBAR_NUM_PORTS],
    input  logic                     s_arready [`XBAR_NUM_PORTS],
    // slave side, read data
    input  logic [`XBAR_DATA_W-1:0]  s_rdata   [`XBAR_NUM_PORTS],
    input  logic [`XBAR_RESP_W-1:0]  s_rresp   [`XBAR_NUM_PORTS],
    input  logic                     s_rlast   [`XBAR_NUM_PORTS],
    input  axi_id_u                  s_rid     [`XBAR_NUM_PORTS],
    input  logic                     s_rvalid  [`XBAR_NUM_PORTS],
    output logic                     s_rready  [`XBAR_NUM_PORTS]
);

    // single shared channel per direction
    axi_ar_if ar_ch ();
    axi_r_if  r_ch ();

    // **************************************************
    // read address path
    // **************************************************
    ar_master_select u_ar_master_select (
        .aclk      (aclk),
        .reset     (reset),
        .m_araddr  (m_araddr),
        .m_arlen   (m_arlen),
        .m_arsize  (m_arsize),
        .m_arburst (m_arburst),
        .m_arid    (m_arid),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .ar        (ar_ch.src)
    );

    ar_slave_steer u_ar_slave_steer (
        .aclk      (aclk),
        .reset     (reset),
        .ar        (ar_ch.dst),
        .s_araddr  (s_araddr),
        .s_arlen   (s_arlen),
        .s_arsize  (s_arsize),
        .s_arburst (s_arburst),
        .s_arid    (s_arid),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready)
    );

    // **************************************************
    // read data path
    // **************************************************
    r_slave_select u_r_slave_select (
        .aclk     (aclk),
        .reset    (reset),
        .s_rdata  (s_rdata),
        .s_rresp  (s_rresp),
        .s_rlast  (s_rlast),
        .s_rid    (s_rid),
        .s_rvalid (s_rvalid),
        .s_rready (s_rready),
        .r        (r_ch.src)
    );

    r_master_steer u_r_master_steer (
        .aclk     (aclk),
        .reset    (reset),
        .r        (r_ch.dst),
        .m_rdata  (m_rdata),
        .m_rresp  (m_rresp),
        .m_rlast  (m_rlast),
        .m_rid    (m_rid),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready)
    );

endmodule

//--- hdl/r_master_steer.sv
`timescale 1ns/1ps
`include "xbar_settings.svh"

module r_master_steer import xbar_pkg::*; (
    input  logic                    aclk,
    input  logic                    reset,
    axi_r_if.dst                    r,
    output logic [`XBAR_DATA_W-1:0] m_rdata  [`XBAR_NUM_PORTS],
    output logic [`XBAR_RESP_W-1:0] m_rresp  [`XBAR_NUM_PORTS],
    output logic                    m_rlast  [`XBAR_NUM_PORTS],
    output axi_id_u                 m_rid    [`XBAR_NUM_PORTS],
    output logic                    m_rvalid [`XBAR_NUM_PORTS],
    input  logic                    m_rready [`XBAR_NUM_PORTS]
);

    logic [`XBAR_NUM_PORTS-1:0] sel;
    logic [`XBAR_NUM_PORTS-1:0] rvalid_vec;

    // requesting master is named in the upper rid bits
    assign sel = code_to_sel(r.id.fields.master_code) & {`XBAR_NUM_PORTS{r.valid}};

    // **************************************************
    // beat fan-out to masters
    // **************************************************
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            m_rdata[i]   = sel[i] ? r.data   : '0;
            m_rresp[i]   = sel[i] ? r.resp   : '0;
            m_rlast[i]   = sel[i] & r.last;
            m_rid[i].raw = sel[i] ? r.id.raw : '0;
            m_rvalid[i]  = sel[i] & r.valid;
        end
    end

    // back-pressure from the addressed master only
    always_comb begin
        r.ready = 1'b0;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            r.ready = r.ready | (sel[i] & m_rready[i]);
        end
    end

    // packed view of the outgoing valids
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            rvalid_vec[i] = m_rvalid[i];
        end
    end

    a_one_rvalid: assert property (
        @(posedge aclk) disable iff (reset) $onehot0(rvalid_vec)
    ) else $error("r_master_steer: beat driven to more than one master");

endmodule

//--- hdl/r_slave_select.sv
`timescale 1ns/1ps
`include "xbar_settings.svh"

module r_slave_select import xbar_pkg::*; (
    input  logic                    aclk,
    input  logic                    reset,
    input  logic [`XBAR_DATA_W-1:0] s_rdata  [`XBAR_NUM_PORTS],
    input  logic [`XBAR_RESP_W-1:0] s_rresp  [`XBAR_NUM_PORTS],
    input  logic                    s_rlast  [`XBAR_NUM_PORTS],
    input  axi_id_u                 s_rid    [`XBAR_NUM_PORTS],
    input  logic                    s_rvalid [`XBAR_NUM_PORTS],
    output logic                    s_rready [`XBAR_NUM_PORTS],
    axi_r_if.src                    r
);

    logic [`XBAR_CODE_W-1:0]    code_or;
    logic [`XBAR_NUM_PORTS-1:0] win_sel;
    logic [`XBAR_NUM_PORTS-1:0] grant;
    logic [`XBAR_NUM_PORTS-1:0] rready_vec;

    // **************************************************
    // priority pick among responding slaves
    // **************************************************
    always_comb begin
        code_or = '0;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            // idle slaves drop out regardless of their rid
            if (s_rvalid[i]) begin
                code_or = code_or | s_rid[i].fields.slave_code;
            end
        end
    end

    assign win_sel = code_to_sel(code_or);

    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            grant[i] = win_sel[i] & s_rvalid[i];
        end
    end

    // winner's beat onto the internal channel
    always_comb begin
        r.data   = '0;
        r.resp   = '0;
        r.last   = 1'b0;
        r.id.raw = '0;
        r.valid  = 1'b0;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            r.data   = r.data   | ({`XBAR_DATA_W{grant[i]}} & s_rdata[i]);
            r.resp   = r.resp   | ({`XBAR_RESP_W{grant[i]}} & s_rresp[i]);
            r.last   = r.last   | (grant[i] & s_rlast[i]);
            r.id.raw = r.id.raw | ({`XBAR_ID_W{grant[i]}}   & s_rid[i].raw);
            r.valid  = r.valid  | (grant[i] & s_rvalid[i]);
        end
    end

    // master's rready goes back to the winning slave alone
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            rready_vec[i] = grant[i] & r.ready;
            s_rready[i]   = rready_vec[i];
        end
    end

    a_one_rready: assert property (
        @(posedge aclk) disable iff (reset) $onehot0(rready_vec)
    ) else $error("r_slave_select: rready seen by more than one slave");

endmodule

//--- hdl/ar_slave_steer.sv
`timescale 1ns/1ps
`include "xbar_settings.svh"

module ar_slave_steer import xbar_pkg::*; (
    input  logic                     aclk,
    input  logic                     reset,
    axi_ar_if.dst                    ar,
    output logic [`XBAR_ADDR_W-1:0]  s_araddr  [`XBAR_NUM_PORTS],
    output logic [`XBAR_LEN_W-1:0]   s_arlen   [`XBAR_NUM_PORTS],
    output logic [`XBAR_SIZE_W-1:0]  s_arsize  [`XBAR_NUM_PORTS],
    output logic [`XBAR_BURST_W-1:0] s_arburst [`XBAR_NUM_PORTS],
    output axi_id_u                  s_arid    [`XBAR_NUM_PORTS],
    output logic                     s_arvalid [`XBAR_NUM_PORTS],
    input  logic                     s_arready [`XBAR_NUM_PORTS]
);

    logic [`XBAR_NUM_PORTS-1:0] sel;
    logic [`XBAR_NUM_PORTS-1:0] arvalid_vec;

    // target slave from the low id bits while a request is up
    assign sel = code_to_sel(ar.id.fields.slave_code) & {`XBAR_NUM_PORTS{ar.valid}};

    // **************************************************
    // request fan-out
    // **************************************************
    // unselected slaves see an all-zero request
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            s_araddr[i]   = sel[i] ? ar.addr   : '0;
            s_arlen[i]    = sel[i] ? ar.len    : '0;
            // size passes straight through
            s_arsize[i]   = sel[i] ? ar.size   : '0;
            s_arburst[i]  = sel[i] ? ar.burst  : '0;
            s_arid[i].raw = sel[i] ? ar.id.raw : '0;
            s_arvalid[i]  = sel[i] & ar.valid;
        end
    end

    // ready from the addressed slave only
    // a bad slave code leaves it low
    always_comb begin
        ar.ready = 1'b0;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            ar.ready = ar.ready | (sel[i] & s_arready[i]);
        end
    end

    // packed copy of the outgoing valids
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            arvalid_vec[i] = s_arvalid[i];
        end
    end

    a_one_arvalid: assert property (
        @(posedge aclk) disable iff (reset) $onehot0(arvalid_vec)
    ) else $error("ar_slave_steer: request driven to more than one slave");

endmodule

//--- hdl/ar_master_select.sv
`timescale 1ns/1ps
`include "xbar_settings.svh"

module ar_master_select import xbar_pkg::*; (
    input  logic                     aclk,
    input  logic                     reset,
    input  logic [`XBAR_ADDR_W-1:0]  m_araddr  [`XBAR_NUM_PORTS],
    input  logic [`XBAR_LEN_W-1:0]   m_arlen   [`XBAR_NUM_PORTS],
    input  logic [`XBAR_SIZE_W-1:0]  m_arsize  [`XBAR_NUM_PORTS],
    input  logic [`XBAR_BURST_W-1:0] m_arburst [`XBAR_NUM_PORTS],
    input  axi_id_u                  m_arid    [`XBAR_NUM_PORTS],
    input  logic                     m_arvalid [`XBAR_NUM_PORTS],
    output logic                     m_arready [`XBAR_NUM_PORTS],
    axi_ar_if.src                    ar
);

    logic [`XBAR_CODE_W-1:0]    code_or;
    logic [`XBAR_NUM_PORTS-1:0] win_sel;
    logic [`XBAR_NUM_PORTS-1:0] grant;
    logic [`XBAR_NUM_PORTS-1:0] arready_vec;

    // **************************************************
    // priority pick
    // **************************************************
    // or of valid masters' codes, the longest thermometer wins
    always_comb begin
        code_or = '0;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            if (m_arvalid[i]) begin
                code_or = code_or | m_arid[i].fields.master_code;
            end
        end
    end

    assign win_sel = code_to_sel(code_or);

    // winner must also be asserting valid
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            grant[i] = win_sel[i] & m_arvalid[i];
        end
    end

    // **************************************************
    // and-or mux onto the internal channel
    // **************************************************
    always_comb begin
        ar.addr   = '0;
        ar.len    = '0;
        ar.size   = '0;
        ar.burst  = '0;
        ar.id.raw = '0;
        ar.valid  = 1'b0;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            ar.addr   = ar.addr   | ({`XBAR_ADDR_W{grant[i]}}  & m_araddr[i]);
            ar.len    = ar.len    | ({`XBAR_LEN_W{grant[i]}}   & m_arlen[i]);
            ar.size   = ar.size   | ({`XBAR_SIZE_W{grant[i]}}  & m_arsize[i]);
            ar.burst  = ar.burst  | ({`XBAR_BURST_W{grant[i]}} & m_arburst[i]);
            ar.id.raw = ar.id.raw | ({`XBAR_ID_W{grant[i]}}    & m_arid[i].raw);
            ar.valid  = ar.valid  | (grant[i] & m_arvalid[i]);
        end
    end

    // ready back to the winner only
    always_comb begin
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            arready_vec[i] = grant[i] & ar.ready;
            m_arready[i]   = arready_vec[i];
        end
    end

    // the slave's ready never fans out to two masters
    a_one_arready: assert property (
        @(posedge aclk) disable iff (reset) $onehot0(arready_vec)
    ) else $error("ar_master_select: arready seen by more than one master");

endmodule

//--- hdl/axi_read_ifs.sv
`timescale 1ns/1ps
`include "xbar_settings.svh"

// **************************************************
// read address channel, master side to slave side
// **************************************************
interface axi_ar_if import xbar_pkg::*; ();

    logic [`XBAR_ADDR_W-1:0]  addr;
    logic [`XBAR_LEN_W-1:0]   len;
    logic [`XBAR_SIZE_W-1:0]  size;
    logic [`XBAR_BURST_W-1:0] burst;
    axi_id_u                  id;
    logic                     valid;
    logic                     ready;

    // driven by the master arbiter
    modport src (
        output addr, len, size, burst, id, valid,
        input  ready
    );

    // consumed by the slave decoder
    modport dst (
        input  addr, len, size, burst, id, valid,
        output ready
    );

endinterface

// **************************************************
// read data channel, slave side to master side
// **************************************************
interface axi_r_if import xbar_pkg::*; ();

    logic [`XBAR_DATA_W-1:0]  data;
    logic [`XBAR_RESP_W-1:0]  resp;
    logic                     last;
    axi_id_u                  id;
    logic                     valid;
    logic                     ready;

    // driven by the slave arbiter
    modport src (
        output data, resp, last, id, valid,
        input  ready
    );

    // consumed by the master decoder
    modport dst (
        input  data, resp, last, id, valid,
        output ready
    );

endinterface

//--- hdl/xbar_pkg.sv
`include "xbar_settings.svh"

package xbar_pkg;

    // one id word, seen whole for muxing
    // or split for routing decisions
    typedef union packed {
        logic [`XBAR_ID_W-1:0] raw;
        struct packed {
            // upper bits, who issued the request
            logic [`XBAR_CODE_W-1:0] master_code;
            // lower bits, who is being addressed
            logic [`XBAR_CODE_W-1:0] slave_code;
        } fields;
    } axi_id_u;

    // thermometer code to one-hot port select
    // 001 -> port 0, 011 -> port 1, 111 -> port 2
    // anything else selects no port
    function automatic logic [`XBAR_NUM_PORTS-1:0] code_to_sel(
        input logic [`XBAR_CODE_W-1:0] code
    );
        logic [`XBAR_NUM_PORTS-1:0] sel;
        logic [`XBAR_CODE_W-1:0]    therm;
        sel   = '0;
        therm = '0;
        for (int i = 0; i < `XBAR_NUM_PORTS; i++) begin
            // grow the thermometer by one bit per port
            therm = {therm[`XBAR_CODE_W-2:0], 1'b1};
            if (code == therm) begin
                sel[i] = 1'b1;
            end
        end
        return sel;
    endfunction

endpackage

//--- hdl/xbar_settings.svh
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// read channel payload widths
`define XBAR_ADDR_W     32
`define XBAR_DATA_W     32
`define XBAR_LEN_W      4
`define XBAR_SIZE_W     3
`define XBAR_BURST_W    2
`define XBAR_RESP_W     2

// id = {master code, slave code}
`define XBAR_ID_W       6
`define XBAR_CODE_W     3

// masters per side, slaves per side
`define XBAR_NUM_PORTS  3

`endif
